/* cart_bus_if.sv */
//======================================
// Console cartridge bus, driven by the top level
//======================================

interface cart_bus_if
	import cart_bus_pkg::*;
();

	logic [CART_AW-1:0] addr;
	logic [CART_DW-1:0] data_wr;
	logic lwr;
	logic oe;
	logic cs;
	// Time register area select, /TIME on the slot
	logic time_cs;

	modport mapper (input addr, data_wr, lwr, time_cs);
	modport memory (input addr, data_wr, lwr, oe, cs);

endinterface

/* cart_bus_pkg.sv */
//======================================
// Console cartridge bus constants
// Shared by the mapper, memory and top level
//======================================

package cart_bus_pkg;

	//======================================
	// Bus widths
	//======================================
	// Word address, byte address bits 23:1
	localparam int CART_AW = 23;
	localparam int CART_DW = 16;

	//======================================
	// SRAM region
	//======================================
	// Battery SRAM is byte wide on the low lane
	localparam int SRAM_DW = CART_DW / 2;
	localparam int REGION_W = 3;
	// Byte address bits 23:21 of the SRAM window
	localparam logic [REGION_W-1:0] SRAM_REGION = 3'd1;

	// SSF2 style bank registers in the time area
	localparam int TIME_BANK_REGS = 8;
	localparam int BANK_W = 6;

endpackage

/* cart_id_pkg.sv */
//======================================
// Cartridge header detection constants
// Serial strings and light-gun timing
//======================================

package cart_id_pkg;

	//======================================
	// Header byte offsets in the download
	//======================================
	localparam int HDR_SERIAL_FIRST = 'h182;
	localparam int HDR_SERIAL_LAST = 'h188;
	// Serial is complete once this word arrives
	localparam int HDR_DECIDE = 'h190;

	//======================================
	// Known serial numbers
	//======================================
	// Game does a fake RAM check
	localparam logic [63:0] SERIAL_NORAM = "T-113016";
	// Expects SRAM cleared to zero
	localparam logic [63:0] SERIAL_SRAM00 = " GM 0000";
	localparam logic [63:0] SERIAL_GUN_A = "MK-1533 ";
	localparam logic [63:0] SERIAL_GUN_B = "T-95096-";

	// Light-gun type and sensor delay
	localparam int GUN_DELAY_W = 8;
	localparam logic GUN_A_TYPE = 1'b0;
	localparam logic [GUN_DELAY_W-1:0] GUN_A_DELAY = 8'd100;
	localparam logic GUN_B_TYPE = 1'b1;
	localparam logic [GUN_DELAY_W-1:0] GUN_B_DELAY = 8'd52;
	localparam logic [GUN_DELAY_W-1:0] GUN_DELAY_DEFAULT = 8'd44;

endpackage

/* cart_memory.sv */
//======================================
// On-chip ROM and battery SRAM
// Registered reads, SRAM clear while downloading
//======================================

module cart_memory
	import cart_bus_pkg::*;
#(
	parameter int ROM_AW = 10,
	parameter int SRAM_AW = 8
)
(
	input  logic               clk,
	input  logic               dl,
	input  logic               sram00,
	cart_bus_if.memory         bus,
	input  logic               rom_we,
	input  logic [ROM_AW-1:0]  rom_waddr,
	input  logic [CART_DW-1:0] rom_wdata,
	input  logic [ROM_AW-1:0]  rom_raddr,
	input  logic               sram_cs,
	output logic [CART_DW-1:0] cart_data,
	output logic               cart_data_en
);

	logic [CART_DW-1:0] rom [2**ROM_AW];
	logic [SRAM_DW-1:0] sram [2**SRAM_AW];
	logic [SRAM_AW-1:0] clr_addr;
	logic [SRAM_AW-1:0] sram_addr;
	logic [SRAM_DW-1:0] sram_wdata;
	logic sram_we;

	//======================================
	// ROM
	//======================================
	always_ff @(posedge clk) begin
		if (rom_we) begin
			rom[rom_waddr] <= rom_wdata;
		end
	end

	//======================================
	// SRAM write port
	//======================================
	// Sweep counter, one byte per cycle during download
	always_ff @(posedge clk) begin
		if (!dl) begin
			clr_addr <= '0;
		end else begin
			clr_addr <= clr_addr + 1'b1;
		end
	end

	always_comb begin
		if (dl) begin
			sram_addr = clr_addr;
			sram_wdata = sram00 ? '0 : '1;
			sram_we = 1'b1;
		end else begin
			sram_addr = bus.addr[SRAM_AW-1:0];
			sram_wdata = bus.data_wr[SRAM_DW-1:0];
			sram_we = bus.lwr & sram_cs;
		end
	end

	always_ff @(posedge clk) begin
		if (sram_we) begin
			sram[sram_addr] <= sram_wdata;
		end
	end

	// Read data, SRAM byte on both lanes and ahead of ROM
	always_ff @(posedge clk) begin
		if (bus.oe && (bus.cs || sram_cs)) begin
			if (sram_cs) begin
				cart_data <= {sram[sram_addr], sram[sram_addr]};
			end else begin
				cart_data <= rom[rom_raddr];
			end
		end
	end

	assign cart_data_en = bus.oe & (bus.cs | sram_cs);

endmodule

/* cart_top.sv */
//======================================
// Cartridge slot top level
// Download port in, console bus in, read data out
//======================================

module cart_top
	import cart_bus_pkg::*;
	import cart_id_pkg::*;
#(
	parameter int ROM_AW = 10,
	parameter int SRAM_AW = 8,
	parameter int WINDOW_AW = 6
)
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   dl,
	input  logic [CART_AW:0]       dl_addr,
	input  logic [CART_DW-1:0]     dl_data,
	input  logic                   dl_wr,
	output logic                   dl_wait,
	input  logic [CART_AW-1:0]     cart_addr,
	input  logic [CART_DW-1:0]     cart_data_wr,
	input  logic                   cart_lwr,
	input  logic                   cart_oe,
	input  logic                   cart_cs,
	input  logic                   cart_time,
	output logic [CART_DW-1:0]     cart_data,
	output logic                   cart_data_en,
	output logic                   gun_type,
	output logic [GUN_DELAY_W-1:0] gun_sensor_delay
);

	logic rom_we;
	logic [ROM_AW-1:0] rom_waddr;
	logic [CART_DW-1:0] rom_wdata;
	logic [ROM_AW:0] rom_sz;
	logic [ROM_AW-1:0] rom_mask;
	logic [ROM_AW-1:0] rom_raddr;
	logic noram;
	logic sram00;
	logic sram_cs;

	cart_bus_if bus ();

	assign bus.addr = cart_addr;
	assign bus.data_wr = cart_data_wr;
	assign bus.lwr = cart_lwr;
	assign bus.oe = cart_oe;
	assign bus.cs = cart_cs;
	assign bus.time_cs = cart_time;

	rom_loader #(.ROM_AW(ROM_AW)) loader_i (
		.clk(clk), .reset(reset), .dl(dl), .dl_wr(dl_wr), .dl_data(dl_data),
		.dl_wait(dl_wait), .rom_we(rom_we), .rom_waddr(rom_waddr),
		.rom_wdata(rom_wdata), .rom_sz(rom_sz), .rom_mask(rom_mask)
	);

	header_detect detect_i (
		.clk(clk), .dl(dl), .dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
		.noram(noram), .sram00(sram00), .gun_type(gun_type),
		.gun_sensor_delay(gun_sensor_delay)
	);

	md_mapper #(.ROM_AW(ROM_AW), .WINDOW_AW(WINDOW_AW)) mapper_i (
		.clk(clk), .reset(reset), .bus(bus.mapper), .rom_sz(rom_sz),
		.rom_mask(rom_mask), .noram(noram), .rom_raddr(rom_raddr), .sram_cs(sram_cs)
	);

	cart_memory #(.ROM_AW(ROM_AW), .SRAM_AW(SRAM_AW)) memory_i (
		.clk(clk), .dl(dl), .sram00(sram00), .bus(bus.memory), .rom_we(rom_we),
		.rom_waddr(rom_waddr), .rom_wdata(rom_wdata), .rom_raddr(rom_raddr),
		.sram_cs(sram_cs), .cart_data(cart_data), .cart_data_en(cart_data_en)
	);

endmodule

/* header_detect.sv */
//======================================
// Reads the serial number from the ROM header
// during download and sets per-game flags
//======================================

module header_detect
	import cart_bus_pkg::*;
	import cart_id_pkg::*;
(
	input  logic                   clk,
	input  logic                   dl,
	input  logic                   dl_wr,
	input  logic [CART_AW:0]       dl_addr,
	input  logic [CART_DW-1:0]     dl_data,
	output logic                   noram,
	output logic                   sram00,
	output logic                   gun_type,
	output logic [GUN_DELAY_W-1:0] gun_sensor_delay
);

	localparam int SERIAL_WORDS = (HDR_SERIAL_LAST - HDR_SERIAL_FIRST) / 2 + 1;

	logic dl_old;
	logic hdr_wr;
	logic [CART_DW-1:0] hdr_word;
	logic [CART_DW*SERIAL_WORDS-1:0] serial;

	// Header bytes arrive swapped within each word
	assign hdr_word = {dl_data[SRAM_DW-1:0], dl_data[CART_DW-1:SRAM_DW]};
	assign hdr_wr = dl & dl_wr;

	//======================================
	// Serial capture
	//======================================
	always_ff @(posedge clk) begin
		if (hdr_wr) begin
			for (int i = 0; i < SERIAL_WORDS; i++) begin
				if (dl_addr == (CART_AW + 1)'(HDR_SERIAL_FIRST + 2 * i)) begin
					// First word holds the leading characters
					serial[CART_DW*(SERIAL_WORDS-i)-1 -: CART_DW] <= hdr_word;
				end
			end
		end
	end

	//======================================
	// Game flags
	//======================================
	always_ff @(posedge clk) begin
		dl_old <= dl;
		if (dl && !dl_old) begin
			noram <= 1'b0;
			sram00 <= 1'b0;
			gun_type <= 1'b0;
			gun_sensor_delay <= GUN_DELAY_DEFAULT;
		end else if (hdr_wr && dl_addr == (CART_AW + 1)'(HDR_DECIDE)) begin
			if (serial == SERIAL_NORAM) begin
				noram <= 1'b1;
			end else if (serial == SERIAL_SRAM00) begin
				sram00 <= 1'b1;
			end
			// Unknown guns keep the defaults
			if (serial == SERIAL_GUN_A) begin
				gun_type <= GUN_A_TYPE;
				gun_sensor_delay <= GUN_A_DELAY;
			end else if (serial == SERIAL_GUN_B) begin
				gun_type <= GUN_B_TYPE;
				gun_sensor_delay <= GUN_B_DELAY;
			end
		end
	end

endmodule

/* md_mapper.sv */
//======================================
// SSF2 style mapper with eight ROM windows
// and the SRAM enable bit in the time area
//======================================

module md_mapper
	import cart_bus_pkg::*;
#(
	parameter int ROM_AW = 10,
	parameter int WINDOW_AW = 6
)
(
	input  logic              clk,
	input  logic              reset,
	cart_bus_if.mapper        bus,
	input  logic [ROM_AW:0]   rom_sz,
	input  logic [ROM_AW-1:0] rom_mask,
	input  logic              noram,
	output logic [ROM_AW-1:0] rom_raddr,
	output logic              sram_cs
);

	localparam int REG_IW = $clog2(TIME_BANK_REGS);

	logic [BANK_W-1:0] bank [TIME_BANK_REGS];
	logic sram_en;
	logic [REG_IW-1:0] reg_idx;
	logic [REG_IW-1:0] win;
	logic [BANK_W+WINDOW_AW-1:0] banked;
	logic in_region;
	logic above_rom;

	assign reg_idx = bus.addr[REG_IW-1:0];

	//======================================
	// Time area registers
	//======================================
	always_ff @(posedge clk) begin
		if (reset) begin
			// Identity mapping
			for (int i = 0; i < TIME_BANK_REGS; i++) begin
				bank[i] <= BANK_W'(i);
			end
			sram_en <= 1'b0;
		end else if (bus.time_cs && bus.lwr) begin
			if (reg_idx == '0) begin
				sram_en <= bus.data_wr[0];
			end else begin
				bank[reg_idx] <= bus.data_wr[BANK_W-1:0];
			end
		end
	end

	// Window index sits just above the in-window offset
	assign win = bus.addr[WINDOW_AW+REG_IW-1:WINDOW_AW];
	assign banked = {bank[win], bus.addr[WINDOW_AW-1:0]};
	assign rom_raddr = banked[ROM_AW-1:0] & rom_mask;

	// SRAM past the end of ROM, or forced by the enable bit
	assign in_region = bus.addr[CART_AW-1 -: REGION_W] == SRAM_REGION;
	assign above_rom = bus.addr >= CART_AW'(rom_sz);
	assign sram_cs = in_region & (sram_en | above_rom) & ~noram;

	// A time register write must not also land in SRAM
	assert property (@(posedge clk) disable iff (reset) bus.time_cs && bus.lwr |-> !sram_cs)
		else $error("Time register write also selects SRAM");

endmodule

/* rom_loader.sv */
//======================================
// Download path into the on-chip ROM
// Tracks image size and address mask
//======================================

module rom_loader
	import cart_bus_pkg::*;
#(
	parameter int ROM_AW = 10
)
(
	input  logic               clk,
	input  logic               reset,
	input  logic               dl,
	input  logic               dl_wr,
	input  logic [CART_DW-1:0] dl_data,
	output logic               dl_wait,
	output logic               rom_we,
	output logic [ROM_AW-1:0]  rom_waddr,
	output logic [CART_DW-1:0] rom_wdata,
	output logic [ROM_AW:0]    rom_sz,
	output logic [ROM_AW-1:0]  rom_mask
);

	logic dl_old;
	logic dl_rise;
	logic [ROM_AW:0] sz_base;
	logic [ROM_AW-1:0] mask_base;

	assign dl_rise = dl & ~dl_old;
	// A new image starts from zero even if the first word comes at once
	assign sz_base = dl_rise ? '0 : rom_sz;
	assign mask_base = dl_rise ? '0 : rom_mask;

	always_ff @(posedge clk) begin
		dl_old <= dl;
		if (reset) begin
			dl_wait <= 1'b0;
			rom_we <= 1'b0;
		end else begin
			rom_we <= dl & dl_wr;
			// One cycle of wait per accepted word
			dl_wait <= dl & dl_wr;
		end
		rom_sz <= sz_base;
		rom_mask <= mask_base;
		if (dl && dl_wr) begin
			rom_waddr <= sz_base[ROM_AW-1:0];
			rom_wdata <= dl_data;
			rom_mask <= mask_base | sz_base[ROM_AW-1:0];
			rom_sz <= sz_base + 1'b1;
		end
	end

	// Host must hold off while the word is being stored
	assert property (@(posedge clk) disable iff (reset) dl_wait |-> !dl_wr)
		else $error("dl_wr raised while dl_wait is high");

endmodule

/* run.sh */
#!/bin/sh
# Builds the cartridge testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_cart -f tb.f -o tb_cart

./obj_dir/tb_cart > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi

/* tb.f */
cart_bus_pkg.sv
cart_id_pkg.sv
cart_bus_if.sv
rom_loader.sv
header_detect.sv
md_mapper.sv
cart_memory.sv
cart_top.sv
tb_cart.sv

/* tb_cart.sv */
//========================================
// Testbench for the cartridge slot top level
// Downloads images, then checks mapper and SRAM
//========================================

module tb_cart
	import cart_bus_pkg::*;
	import cart_id_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 4;
	localparam int ROM_AW = 10;
	localparam int SRAM_AW = 8;
	localparam int WINDOW_AW = 6;
	localparam int WIN_WORDS = 1 << WINDOW_AW;
	localparam int IMAGE_WORDS = 1024;
	localparam int NUM_DOWNLOADS = 5;
	// Three clocks per word, doubled, plus room for the bus tests
	localparam int WATCHDOG_NS = NUM_DOWNLOADS * IMAGE_WORDS * 3 * CLK_PERIOD * 2 + 20000;
	localparam int SERIAL_WORDS = (HDR_SERIAL_LAST - HDR_SERIAL_FIRST) / 2 + 1;
	localparam logic [CART_AW-1:0] SRAM_BASE = {SRAM_REGION, {(CART_AW-REGION_W){1'b0}}};
	localparam logic [63:0] SERIAL_OTHER = "GM 00001";

	logic clk, reset, dl, dl_wr, dl_wait;
	logic [CART_AW:0] dl_addr;
	logic [CART_DW-1:0] dl_data, cart_data_wr, cart_data;
	logic [CART_AW-1:0] cart_addr;
	logic cart_lwr, cart_oe, cart_cs, cart_time, cart_data_en, gun_type;
	logic [GUN_DELAY_W-1:0] gun_sensor_delay;

	// Reference state of the image and the bank registers
	logic [BANK_W-1:0] bank_model [TIME_BANK_REGS];
	logic [63:0] cur_serial;
	int rom_mask_model;

	cart_top #(.ROM_AW(ROM_AW), .SRAM_AW(SRAM_AW), .WINDOW_AW(WINDOW_AW)) dut_i (
		.clk(clk), .reset(reset), .dl(dl), .dl_addr(dl_addr), .dl_data(dl_data),
		.dl_wr(dl_wr), .dl_wait(dl_wait), .cart_addr(cart_addr),
		.cart_data_wr(cart_data_wr), .cart_lwr(cart_lwr), .cart_oe(cart_oe),
		.cart_cs(cart_cs), .cart_time(cart_time), .cart_data(cart_data),
		.cart_data_en(cart_data_en), .gun_type(gun_type),
		.gun_sensor_delay(gun_sensor_delay)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all tests completed");
		$display("Test failed");
		$fatal(1, "timeout");
	end

	task automatic expect_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			$display("Test failed");
			$fatal(1, "check on %s", name);
		end
	endtask

	// Word i holds i, the serial words carry the string byte-swapped
	function automatic logic [CART_DW-1:0] image_word(input int idx, input logic [63:0] serial);
		int hdr;
		logic [CART_DW-1:0] chars;
		hdr = idx - HDR_SERIAL_FIRST / 2;
		if (hdr >= 0 && hdr < SERIAL_WORDS) begin
			chars = serial[63 - 16 * hdr -: 16];
			return {chars[7:0], chars[15:8]};
		end
		return CART_DW'(idx);
	endfunction

	function automatic logic [CART_DW-1:0] expected_rom(input logic [CART_AW-1:0] addr);
		int win;
		int idx;
		win = (addr / WIN_WORDS) % TIME_BANK_REGS;
		idx = (bank_model[win] * WIN_WORDS + addr % WIN_WORDS) & rom_mask_model;
		return image_word(idx, cur_serial);
	endfunction

	task automatic apply_reset();
		reset <= 1'b1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < TIME_BANK_REGS; i++) begin
			bank_model[i] = BANK_W'(i);
		end
	endtask

	task automatic download_image(input logic [63:0] serial);
		@(posedge clk);
		dl <= 1'b1;
		rom_mask_model = 0;
		for (int i = 0; i < IMAGE_WORDS; i++) begin
			@(posedge clk);
			dl_wr <= 1'b1;
			dl_addr <= (CART_AW + 1)'(2 * i);
			dl_data <= image_word(i, serial);
			rom_mask_model |= i;
			@(posedge clk);
			dl_wr <= 1'b0;
			// Wait flag lasts exactly one cycle
			@(negedge clk);
			expect_equal("dl_wait", dl_wait, 1'b1);
			@(negedge clk);
			expect_equal("dl_wait", dl_wait, 1'b0);
		end
		@(posedge clk);
		dl <= 1'b0;
		cur_serial = serial;
	endtask

	task automatic read_word(input logic [CART_AW-1:0] addr, input logic use_cs,
		output logic [CART_DW-1:0] data, output logic en);
		@(posedge clk);
		cart_addr <= addr;
		cart_oe <= 1'b1;
		cart_cs <= use_cs;
		@(posedge clk);
		@(negedge clk);
		data = cart_data;
		en = cart_data_en;
		@(posedge clk);
		cart_oe <= 1'b0;
		cart_cs <= 1'b0;
	endtask

	task automatic write_word(input logic [CART_AW-1:0] addr, input logic [CART_DW-1:0] data,
		input logic to_time);
		@(posedge clk);
		cart_addr <= addr;
		cart_data_wr <= data;
		cart_lwr <= 1'b1;
		cart_time <= to_time;
		@(posedge clk);
		cart_lwr <= 1'b0;
		cart_time <= 1'b0;
	endtask

	task automatic check_gun(input logic exp_type, input logic [GUN_DELAY_W-1:0] exp_delay);
		@(negedge clk);
		expect_equal("gun_type", gun_type, exp_type);
		expect_equal("gun_sensor_delay", gun_sensor_delay, exp_delay);
	endtask

	//========================================
	// Directed tests
	//========================================
	task automatic identity_bank_reads();
		logic [CART_AW-1:0] addr;
		logic [CART_DW-1:0] data;
		logic en;
		for (int n = 0; n < 4 * TIME_BANK_REGS; n++) begin
			addr = CART_AW'((n % TIME_BANK_REGS) * WIN_WORDS + $urandom_range(WIN_WORDS - 1));
			read_word(addr, 1'b1, data, en);
			expect_equal("cart_data", data, expected_rom(addr));
			expect_equal("cart_data_en", en, 1'b1);
		end
		// First serial word, swapped back by nothing on the read side
		addr = CART_AW'(HDR_SERIAL_FIRST / 2);
		read_word(addr, 1'b1, data, en);
		expect_equal("cart_data", data, expected_rom(addr));
	endtask

	task automatic bank_switch_reads();
		logic [CART_DW-1:0] data;
		logic en;
		write_word(CART_AW'(1), CART_DW'(3), 1'b1);
		for (int off = 0; off < WIN_WORDS; off += 9) begin
			read_word(CART_AW'(WIN_WORDS + off), 1'b1, data, en);
			expect_equal("cart_data", data, image_word(3 * WIN_WORDS + off, cur_serial));
		end
		apply_reset();
		for (int off = 0; off < WIN_WORDS; off += 9) begin
			read_word(CART_AW'(WIN_WORDS + off), 1'b1, data, en);
			expect_equal("cart_data", data, image_word(WIN_WORDS + off, cur_serial));
		end
	endtask

	task automatic sram_fill_and_write();
		logic [CART_DW-1:0] data;
		logic [7:0] val;
		logic en;
		read_word(SRAM_BASE + 23'h21, 1'b1, data, en);
		expect_equal("cart_data", data, 16'hffff);
		write_word(SRAM_BASE + 23'h21, 16'h005a, 1'b0);
		// Chip select from the mapper alone enables the output
		read_word(SRAM_BASE + 23'h21, 1'b0, data, en);
		expect_equal("cart_data", data, 16'h5a5a);
		expect_equal("cart_data_en", en, 1'b1);
		val = 8'($urandom);
		write_word(SRAM_BASE + 23'h80, {8'h00, val}, 1'b0);
		read_word(SRAM_BASE + 23'h80, 1'b1, data, en);
		expect_equal("cart_data", data, {val, val});
	endtask

	task automatic sram00_zero_clear();
		logic [CART_DW-1:0] data;
		logic en;
		download_image(SERIAL_SRAM00);
		check_gun(1'b0, GUN_DELAY_DEFAULT);
		for (int n = 0; n < 8; n++) begin
			read_word(SRAM_BASE + CART_AW'($urandom_range((1 << SRAM_AW) - 1)), 1'b1, data, en);
			expect_equal("cart_data", data, 16'h0000);
		end
	endtask

	task automatic noram_blocks_sram();
		logic [CART_DW-1:0] data;
		logic en;
		download_image(SERIAL_NORAM);
		read_word(SRAM_BASE + 23'h21, 1'b0, data, en);
		expect_equal("cart_data_en", en, 1'b0);
	endtask

	task automatic gun_serial_decode();
		download_image(SERIAL_GUN_A);
		check_gun(1'b0, 8'd100);
		download_image(SERIAL_GUN_B);
		check_gun(1'b1, 8'd52);
	endtask

	initial begin
		void'($urandom(32'hd0aca37f));
		reset = 1'b1;
		dl = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		cart_addr = '0;
		cart_data_wr = '0;
		cart_lwr = 1'b0;
		cart_oe = 1'b0;
		cart_cs = 1'b0;
		cart_time = 1'b0;
		cur_serial = '0;
		rom_mask_model = 0;
		apply_reset();
		download_image(SERIAL_OTHER);
		check_gun(1'b0, GUN_DELAY_DEFAULT);
		apply_reset();
		identity_bank_reads();
		bank_switch_reads();
		sram_fill_and_write();
		sram00_zero_clear();
		noram_blocks_sram();
		gun_serial_decode();
		$display("Test passed");
		$finish;
	end

endmodule
